//--- vlog.f
hw/cpu_isa_pkg.sv
hw/cpu_ctrl_pkg.sv
hw/stack_decoder.sv
hw/stack_alu.sv
hw/stack_regs.sv
hw/cpu_sequencer.sv
hw/bus_wait_timer.sv
hw/stack_cpu_top.sv
test/tb_stack_cpu.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_stack_cpu
FILELIST  = vlog.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- test/tb_stack_cpu.sv
module tb_stack_cpu import cpu_ctrl_pkg::*;;

  localparam int n_prog   = 4;
  localparam int max_insn = 48;
  localparam int max_st   = 12;
  localparam int rounds   = 2;
  // exec plus two handshakes of up to 3 + 2 cycles per edge
  localparam int insn_cycles = 1 + 2 * 2 * (3 + 2);
  localparam int cycle_limit = (rounds * n_prog + 2) * (max_insn * insn_cycles + 20)
                               + 8 * bus_timeout;

  logic        clk;
  logic        rst_n;
  logic        mem_ack;
  logic [15:0] mem_rdata;
  logic        mem_req;
  logic        mem_we;
  logic        mem_byte;
  logic [15:0] mem_addr;
  logic [15:0] mem_wdata;
  logic        bus_fault;

  logic [15:0] ram [32768];
  logic [15:0] prog_words [n_prog][max_insn];
  int          prog_len [n_prog];
  logic [15:0] exp_addr [n_prog][max_st];
  logic [15:0] exp_data [n_prog][max_st];
  int          exp_cnt [n_prog];
  logic [15:0] st_addr [$];
  logic [15:0] st_data [$];
  logic [15:0] lfsr;
  logic        end_seen;
  logic        withhold;
  logic        req_q;
  logic        ack_q;
  int          cycles;
  int          errors;

  stack_cpu_top u_stack_cpu_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_byte  (mem_byte),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .bus_fault (bus_fault)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > cycle_limit)
    begin
      $display("Run exceeded %0d cycles without finishing", cycle_limit);
      $display("Test failed");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check(input logic [15:0] got, input logic [15:0] want, input string what);
    if (got !== want)
    begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, want);
      $display("Test failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  // ********************
  // ack delay source
  function automatic logic next_bit();
    lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    return lfsr[0];
  endfunction

  function automatic int draw_delay();
    int d;
    d = int'(next_bit());
    d = d * 2 + int'(next_bit());
    return d;  // 0 to 3
  endfunction

  function automatic logic [15:0] fill_word(input logic [15:0] addr);
    return addr ^ 16'ha5c3;
  endfunction

  // memory model, four-phase slave
  initial
  begin
    int wait_cnt;
    mem_ack   = 1'b0;
    mem_rdata = 16'h0000;
    wait_cnt  = 0;
    forever
    begin
      @(posedge clk);
      #2;
      if (!rst_n)
      begin
        mem_ack  = 1'b0;
        wait_cnt = 0;
      end
      else if (mem_req && !mem_ack && !withhold)
      begin
        if (wait_cnt != 0)
          wait_cnt--;
        else
        begin
          check({15'h0, mem_byte}, 16'h0, "mem_byte on a word access");  // programs use words
          if (mem_we)
          begin
            ram[mem_addr[15:1]] = mem_wdata;
            if (mem_addr == 16'hfffe)
              end_seen = 1'b1;
            else
            begin
              st_addr.push_back(mem_addr);
              st_data.push_back(mem_wdata);
            end
          end
          else
            mem_rdata = ram[mem_addr[15:1]];
          mem_ack  = 1'b1;
          wait_cnt = draw_delay();
        end
      end
      else if (!mem_req && mem_ack)
      begin
        if (wait_cnt != 0)
          wait_cnt--;
        else
        begin
          mem_ack  = 1'b0;
          wait_cnt = draw_delay();
        end
      end
    end
  end

  // ack as it stood on the cycle before req rose
  always @(negedge clk)
  begin
    if (rst_n && mem_req && !req_q)
      check({15'h0, ack_q}, 16'h0, "mem_ack high at new request");
    req_q = mem_req;
    ack_q = mem_ack;
  end

  // ********************
  // program table
  function automatic logic [15:0] lit(input logic [15:0] v);
    return {1'b1, v[14:0]};
  endfunction

  task automatic emit(input int p, input logic [15:0] w);
    prog_words[p][prog_len[p]] = w;
    prog_len[p]++;
  endtask

  task automatic expect_store(input int p, input logic [15:0] a, input logic [15:0] d);
    exp_addr[p][exp_cnt[p]] = a;
    exp_data[p][exp_cnt[p]] = d;
    exp_cnt[p]++;
  endtask

  // 0 - 2 gives fffe, then misc store of the 0 below it
  task automatic emit_end(input int p);
    emit(p, lit(16'h0));
    emit(p, lit(16'h0));
    emit(p, lit(16'h2));
    emit(p, 16'h7042);
    emit(p, 16'h780c);
  endtask

  task automatic alu_case(input int p, input logic [15:0] a, input logic [15:0] b,
                          input logic [5:0] sel, input logic [15:0] addr,
                          input logic [15:0] want);
    emit(p, lit(a));
    emit(p, lit(b));
    emit(p, 16'h7040 | 16'(sel));  // pop second operand
    emit(p, 16'h3400 | addr);      // store at fp + addr, fp is zero
    expect_store(p, addr, want);
  endtask

  task automatic build_table();
    for (int p = 0; p < n_prog; p++)
    begin
      prog_len[p] = 0;
      exp_cnt[p]  = 0;
    end
    // register ops
    alu_case(0, 16'h1234, 16'h0456, 6'h01, 16'h200, 16'h1234 + 16'h0456);
    alu_case(0, 16'h1234, 16'h0456, 6'h02, 16'h202, 16'h1234 - 16'h0456);
    alu_case(0, 16'h1234, 16'h0456, 6'h03, 16'h204, 16'h1234 & 16'h0456);
    alu_case(0, 16'h1234, 16'h0456, 6'h04, 16'h206, 16'h1234 | 16'h0456);
    alu_case(0, 16'h1234, 16'h0456, 6'h05, 16'h208, 16'h1234 ^ 16'h0456);
    alu_case(0, 16'h0f0f, 16'h0004, 6'h06, 16'h20a, 16'hf0f0);
    alu_case(0, 16'h7421, 16'h0003, 6'h07, 16'h20c, 16'h0e84);
    emit(0, lit(16'h0aaa));
    emit(0, lit(16'h0bbb));
    emit(0, 16'h7008);             // swap
    emit(0, 16'h3400 | 16'h20e);
    emit(0, 16'h3400 | 16'h210);
    expect_store(0, 16'h20e, 16'h0aaa);
    expect_store(0, 16'h210, 16'h0bbb);
    emit_end(0);
    // loads and stores, fp moved to 0100
    emit(1, 16'h5100);
    emit(1, lit(16'h1111));
    emit(1, 16'h3400 | 16'h102);
    emit(1, 16'h2400 | 16'h102);
    emit(1, 16'h3400 | 16'h104);
    emit(1, 16'h2400 | 16'h2f0);   // untouched word at 03f0
    emit(1, 16'h3400 | 16'h106);
    emit(1, 16'h4400 | 16'h120);   // push fp + 0120
    emit(1, 16'h3000 | 16'h010);   // store top at top + 0010
    emit(1, lit(16'h3333));
    emit(1, 16'h4400 | 16'h140);
    emit(1, 16'h780e);             // second entry to address in top
    emit(1, 16'h4400 | 16'h140);
    emit(1, 16'h7808);             // load from top
    emit(1, 16'h3400 | 16'h142);
    emit(1, 16'h3400 | 16'h144);
    expect_store(1, 16'h202, 16'h1111);
    expect_store(1, 16'h204, 16'h1111);
    expect_store(1, 16'h206, fill_word(16'h3f0));
    expect_store(1, 16'h230, 16'h220);
    expect_store(1, 16'h240, 16'h3333);
    expect_store(1, 16'h242, 16'h3333);
    expect_store(1, 16'h244, 16'h3333);
    emit_end(1);
    // branches, each skip jumps over a two word store block
    emit(2, lit(16'h0));
    emit(2, 16'h1006);             // bz taken
    emit(2, lit(16'h0bad));
    emit(2, 16'h3400 | 16'h200);
    emit(2, lit(16'h1));
    emit(2, 16'h1006);             // bz not taken
    emit(2, lit(16'h00a1));
    emit(2, 16'h3400 | 16'h202);
    emit(2, lit(16'h5));
    emit(2, 16'h1007);             // bnz taken
    emit(2, lit(16'h0bad));
    emit(2, 16'h3400 | 16'h204);
    emit(2, lit(16'h0));
    emit(2, 16'h1007);             // bnz not taken
    emit(2, lit(16'h00a2));
    emit(2, 16'h3400 | 16'h206);
    emit(2, 16'h0006);             // jump
    emit(2, lit(16'h0bad));
    emit(2, 16'h3400 | 16'h208);
    emit(2, lit(16'h00a3));
    emit(2, 16'h3400 | 16'h20a);
    expect_store(2, 16'h202, 16'h00a1);
    expect_store(2, 16'h206, 16'h00a2);
    expect_store(2, 16'h20a, 16'h00a3);
    emit_end(2);
    // call and return with fp saved on the call stack
    emit(3, 16'h5080);             // 00 fp = 0080
    emit(3, 16'h7803);             // 02 push fp
    emit(3, 16'h000d);             // 04 call 0010
    emit(3, lit(16'h00c2));        // 06
    emit(3, 16'h3400 | 16'h200);   // 08
    emit(3, 16'h5010);             // 0a fp = 0090
    emit(3, 16'h7802);             // 0c pop fp
    emit(3, 16'h000e);             // 0e jump 001c
    emit(3, 16'h7803);             // 10 sub, save fp
    emit(3, 16'h5040);             // 12 fp = 00c0
    emit(3, lit(16'h00c1));        // 14
    emit(3, 16'h3400 | 16'h200);   // 16
    emit(3, 16'h7802);             // 18 restore fp
    emit(3, 16'h7800);             // 1a return
    emit(3, lit(16'h00c3));        // 1c
    emit(3, 16'h3400 | 16'h200);   // 1e
    expect_store(3, 16'h2c0, 16'h00c1);
    expect_store(3, 16'h280, 16'h00c2);
    expect_store(3, 16'h280, 16'h00c3);
    emit_end(3);
  endtask

  // ********************
  // run control
  task automatic apply_reset();
    @(posedge clk);
    #2 rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #2 rst_n = 1'b1;
  endtask

  task automatic load_ram(input int p);
    for (int i = 0; i < 32768; i++)
      ram[i] = fill_word({i[14:0], 1'b0});
    for (int i = 0; i < prog_len[p]; i++)
      ram[i] = prog_words[p][i];
  endtask

  task automatic run_program(input int p);
    load_ram(p);
    st_addr.delete();
    st_data.delete();
    end_seen = 1'b0;
    apply_reset();
    check({15'h0, bus_fault}, 16'h0, "bus_fault after reset");
    while (!end_seen)
      @(posedge clk);
    check(16'(st_addr.size()), 16'(exp_cnt[p]), $sformatf("store count, program %0d", p));
    for (int k = 0; k < exp_cnt[p] && k < st_addr.size(); k++)
    begin
      check(st_addr[k], exp_addr[p][k], $sformatf("store %0d address, program %0d", k, p));
      check(st_data[k], exp_data[p][k], $sformatf("store %0d data, program %0d", k, p));
    end
  endtask

  task automatic fault_test();
    int n;
    load_ram(0);
    withhold = 1'b1;
    apply_reset();
    n = 0;
    while (!bus_fault && n < 4 * bus_timeout)
    begin
      @(negedge clk);
      n++;
    end
    if (!bus_fault)
    begin
      $display("bus_fault did not rise while ack was withheld");
      $display("Test failed");
      $fatal(1, "no bus fault");
    end
    repeat (20)
    begin
      @(negedge clk);
      check({15'h0, mem_req}, 16'h0, "mem_req after fault");
      check({15'h0, bus_fault}, 16'h1, "bus_fault held");
    end
    @(posedge clk);
    #2 withhold = 1'b0;
  endtask

  initial
  begin
    rst_n    = 1'b0;
    withhold = 1'b0;
    end_seen = 1'b0;
    req_q    = 1'b0;
    ack_q    = 1'b0;
    cycles   = 0;
    errors   = 0;
    lfsr     = 16'd38270;
    build_table();
    for (int r = 0; r < rounds; r++)
      for (int p = 0; p < n_prog; p++)
        run_program(p);
    fault_test();
    run_program(0);  // normal again after the fault
    if (errors == 0)
    begin
      $display("Test completed successfully");
      $finish;
    end
    else
    begin
      $display("Test failed");
      $fatal(1, "errors found");
    end
  end

endmodule

//--- hw/stack_cpu_top.sv
module stack_cpu_top import cpu_isa_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              mem_ack,
  input  logic [word_w-1:0] mem_rdata,
  output logic              mem_req,
  output logic              mem_we,
  output logic              mem_byte,
  output logic [word_w-1:0] mem_addr,
  output logic [word_w-1:0] mem_wdata,
  output logic              bus_fault
);

  insn_t             insn;
  logic              commit;
  logic              waiting;
  logic              timeout;
  logic [word_w-1:0] load_data;

  // decoder controls
  logic              imm;
  logic [word_w-1:0] imm_mask;
  logic [1:0]        src_a;
  logic [5:0]        alu_sel;
  logic              wr_stk1;
  logic              pop;
  logic              push;
  logic              load_stk;
  logic              load_fp;
  logic              load_ip;
  logic              cpop;
  logic              cpush;
  logic              byt;
  logic              rd_mem;
  logic              wr_mem;

  logic [word_w-1:0] alu_y;
  logic              take_branch;
  logic [word_w-1:0] stk0;
  logic [word_w-1:0] stk1;
  logic [word_w-1:0] fp;
  logic [word_w-1:0] ip;
  logic [word_w-1:0] cstk0;

  cpu_sequencer u_cpu_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .rd_mem    (rd_mem),
    .wr_mem    (wr_mem),
    .byt       (byt),
    .ip        (ip),
    .alu_y     (alu_y),
    .stk0      (stk0),
    .stk1      (stk1),
    .timeout   (timeout),
    .insn      (insn),
    .commit    (commit),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_byte  (mem_byte),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .waiting   (waiting),
    .bus_fault (bus_fault),
    .load_data (load_data)
  );

  stack_decoder u_stack_decoder (
    .insn     (insn),
    .imm      (imm),
    .imm_mask (imm_mask),
    .src_a    (src_a),
    .alu_sel  (alu_sel),
    .wr_stk1  (wr_stk1),
    .pop      (pop),
    .push     (push),
    .load_stk (load_stk),
    .load_fp  (load_fp),
    .load_ip  (load_ip),
    .cpop     (cpop),
    .cpush    (cpush),
    .byt      (byt),
    .rd_mem   (rd_mem),
    .wr_mem   (wr_mem)
  );

  stack_alu u_stack_alu (
    .insn        (insn),
    .src_a       (src_a),
    .alu_sel     (alu_sel),
    .imm         (imm),
    .imm_mask    (imm_mask),
    .stk0        (stk0),
    .stk1        (stk1),
    .fp          (fp),
    .ip          (ip),
    .cstk0       (cstk0),
    .alu_y       (alu_y),
    .take_branch (take_branch)
  );

  stack_regs #(
    .stack_depth (8)
  ) u_stack_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .commit      (commit),
    .pop         (pop),
    .push        (push),
    .load_stk    (load_stk),
    .load_fp     (load_fp),
    .load_ip     (load_ip),
    .cpop        (cpop),
    .cpush       (cpush),
    .wr_stk1     (wr_stk1),
    .take_branch (take_branch),
    .rd_mem      (rd_mem),
    .alu_y       (alu_y),
    .load_data   (load_data),
    .stk0        (stk0),
    .stk1        (stk1),
    .fp          (fp),
    .ip          (ip),
    .cstk0       (cstk0)
  );

  bus_wait_timer u_bus_wait_timer (
    .clk     (clk),
    .rst_n   (rst_n),
    .waiting (waiting),
    .mem_ack (mem_ack),
    .timeout (timeout)
  );

endmodule

//--- hw/bus_wait_timer.sv
module bus_wait_timer import cpu_ctrl_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic waiting,
  input  logic mem_ack,
  output logic timeout
);

  logic               ack_q;
  logic [timer_w-1:0] count;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack_q <= 1'b0;
      count <= '0;
    end
    else
    begin
      ack_q <= mem_ack;
      if (!waiting || (mem_ack != ack_q))
        count <= '0;  // new phase
      else if (!timeout)
        count <= count + 1'b1;
    end
  end

  assign timeout = count == timer_w'(bus_timeout);

endmodule

//--- hw/cpu_sequencer.sv
module cpu_sequencer
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              mem_ack,
  input  logic [word_w-1:0] mem_rdata,
  input  logic              rd_mem,
  input  logic              wr_mem,
  input  logic              byt,
  input  logic [word_w-1:0] ip,
  input  logic [word_w-1:0] alu_y,
  input  logic [word_w-1:0] stk0,
  input  logic [word_w-1:0] stk1,
  input  logic              timeout,
  output insn_t             insn,
  output logic              commit,
  output logic              mem_req,
  output logic              mem_we,
  output logic              mem_byte,
  output logic [word_w-1:0] mem_addr,
  output logic [word_w-1:0] mem_wdata,
  output logic              waiting,
  output logic              bus_fault,
  output logic [word_w-1:0] load_data
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        mem_op;

  assign mem_op = rd_mem | wr_mem;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= idle;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      idle:
        if (!mem_ack)
          state_next = fetch;
      fetch:
        if (mem_ack)
          state_next = fetch_rel;
      fetch_rel:
        if (!mem_ack)
          state_next = exec;
      exec:
        state_next = mem_op ? mem : fetch;
      mem:
        if (mem_ack)
          state_next = mem_rel;
      mem_rel:
        if (!mem_ack)
          state_next = fetch;
      default:
        state_next = fault;  // held until reset
    endcase
    if (timeout)
      state_next = fault;
  end

  // instruction and read data latched on ack
  always_ff @(posedge clk)
  begin
    if (state == fetch && mem_ack)
      insn <= mem_rdata;
    if (state == mem && mem_ack && rd_mem)
      load_data <= byt ? word_w'(mem_rdata[7:0]) : mem_rdata;
  end

  // ********************
  // bus and control outputs
  assign mem_req   = (state == fetch) || (state == mem);
  assign mem_we    = (state == mem) && wr_mem;
  assign mem_byte  = (state == mem) && byt;
  assign mem_addr  = (state == mem) ? alu_y : ip;
  assign mem_wdata = (insn.op.major == op_reg) ? stk1 : stk0;  // misc store
  assign waiting   = state inside {fetch, fetch_rel, mem, mem_rel};
  assign bus_fault = state == fault;
  assign commit    = (state == exec && !mem_op) || (state == mem_rel && !mem_ack);

  a_req_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(mem_req) |-> $past(mem_ack) || bus_fault)
    else $error("mem_req dropped before mem_ack at %0t", $time);

  a_req_after_release: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(mem_req) |-> !$past(mem_ack))
    else $error("mem_req raised while mem_ack high at %0t", $time);

endmodule

//--- hw/stack_regs.sv
module stack_regs import cpu_isa_pkg::*; #(
  parameter int stack_depth = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              commit,
  input  logic              pop,
  input  logic              push,
  input  logic              load_stk,
  input  logic              load_fp,
  input  logic              load_ip,
  input  logic              cpop,
  input  logic              cpush,
  input  logic              wr_stk1,
  input  logic              take_branch,
  input  logic              rd_mem,
  input  logic [word_w-1:0] alu_y,
  input  logic [word_w-1:0] load_data,
  output logic [word_w-1:0] stk0,
  output logic [word_w-1:0] stk1,
  output logic [word_w-1:0] fp,
  output logic [word_w-1:0] ip,
  output logic [word_w-1:0] cstk0
);

  localparam int cnt_w = $clog2(stack_depth + 1);

  logic [word_w-1:0] dstk [stack_depth];
  logic [word_w-1:0] cstk [stack_depth];
  logic [cnt_w-1:0]  dcnt;
  logic [cnt_w-1:0]  ccnt;
  logic [word_w-1:0] top_in;
  logic [word_w-1:0] ip_next;

  assign top_in  = rd_mem ? load_data : alu_y;
  assign ip_next = ip + 16'd2;
  assign stk0    = dstk[0];
  assign stk1    = dstk[1];
  assign cstk0   = cstk[0];

  // ********************
  // data stack, entry 0 is the top
  always_ff @(posedge clk)
  begin
    if (commit)
    begin
      if (push && !pop)
      begin
        for (int i = stack_depth - 1; i > 0; i--)
          dstk[i] <= dstk[i - 1];
      end
      else if (pop && !push)
      begin
        for (int i = 1; i < stack_depth - 1; i++)
          dstk[i] <= dstk[i + 1];
        if (!load_stk)
          dstk[0] <= dstk[1];
      end
      if (load_stk)
        dstk[0] <= top_in;
      if (wr_stk1)
        dstk[1] <= dstk[0];  // old top into second entry
    end
  end

  always_ff @(posedge clk)
  begin
    if (commit && cpush)
    begin
      for (int i = stack_depth - 1; i > 0; i--)
        cstk[i] <= cstk[i - 1];
      cstk[0] <= load_ip ? ip_next : alu_y;  // return address on a call
    end
    else if (commit && cpop)
    begin
      for (int i = 0; i < stack_depth - 1; i++)
        cstk[i] <= cstk[i + 1];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dcnt <= '0;
      ccnt <= '0;
      ip   <= '0;
      fp   <= '0;
    end
    else if (commit)
    begin
      dcnt <= dcnt + cnt_w'(push) - cnt_w'(pop);
      ccnt <= ccnt + cnt_w'(cpush) - cnt_w'(cpop);
      ip   <= (load_ip && take_branch) ? alu_y : ip_next;
      if (load_fp)
        fp <= alu_y;
    end
  end

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    commit |-> !(pop && !push && dcnt == '0) && !(cpop && ccnt == '0))
    else $error("stack underflow at %0t", $time);

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    commit |-> !(push && !pop && dcnt == stack_depth) && !(cpush && ccnt == stack_depth))
    else $error("stack overflow at %0t", $time);

endmodule

//--- hw/stack_alu.sv
module stack_alu import cpu_isa_pkg::*; (
  input  insn_t             insn,
  input  logic [1:0]        src_a,
  input  logic [5:0]        alu_sel,
  input  logic              imm,
  input  logic [word_w-1:0] imm_mask,
  input  logic [word_w-1:0] stk0,
  input  logic [word_w-1:0] stk1,
  input  logic [word_w-1:0] fp,
  input  logic [word_w-1:0] ip,
  input  logic [word_w-1:0] cstk0,
  output logic [word_w-1:0] alu_y,
  output logic              take_branch
);

  logic [word_w-1:0] a;
  logic [word_w-1:0] offset;
  logic [3:0]        shamt;

  always_comb
  begin
    case (src_a)
      src_stk0: a = stk0;
      src_fp:   a = fp;
      src_ip:   a = ip;
      default:  a = cstk0;
    endcase
  end

  assign offset = {1'b0, insn.lit.value} & imm_mask;
  assign shamt  = a[3:0];

  always_comb
  begin
    if (imm)
    begin
      if (alu_sel == alu_lit)
        alu_y = offset;
      else
        alu_y = a + offset;  // addr, jump and branch targets
    end
    else
    begin
      case (alu_sel)
        alu_add:  alu_y = stk1 + a;
        alu_sub:  alu_y = stk1 - a;
        alu_and:  alu_y = stk1 & a;
        alu_or:   alu_y = stk1 | a;
        alu_xor:  alu_y = stk1 ^ a;
        alu_shl:  alu_y = stk1 << shamt;
        alu_shr:  alu_y = stk1 >> shamt;
        alu_swap: alu_y = stk1;
        default:  alu_y = a;  // pass source
      endcase
    end
  end

  always_comb
  begin
    case (alu_sel)
      alu_bz:  take_branch = stk0 == '0;
      alu_bnz: take_branch = stk0 != '0;
      default: take_branch = 1'b1;
    endcase
  end

endmodule

//--- hw/stack_decoder.sv
module stack_decoder import cpu_isa_pkg::*; (
  input  insn_t             insn,
  output logic              imm,
  output logic [word_w-1:0] imm_mask,
  output logic [1:0]        src_a,
  output logic [5:0]        alu_sel,
  output logic              wr_stk1,
  output logic              pop,
  output logic              push,
  output logic              load_stk,
  output logic              load_fp,
  output logic              load_ip,
  output logic              cpop,
  output logic              cpush,
  output logic              byt,
  output logic              rd_mem,
  output logic              wr_mem
);

  assign imm = insn.op.major != op_reg;
  assign byt = insn.op.low[0];

  always_comb
  begin
    casez (insn.op.major)
      4'b1???: imm_mask = 16'h7fff;
      4'b000?: imm_mask = 16'h0ffe;  // jump, branch
      4'b001?: imm_mask = 16'h03fe;  // load, store
      default: imm_mask = 16'h03ff;
    endcase
  end

  always_comb
  begin
    src_a    = src_stk0;
    alu_sel  = 6'h00;
    wr_stk1  = 1'b0;
    pop      = 1'b0;
    push     = 1'b0;
    load_stk = 1'b0;
    load_fp  = 1'b0;
    load_ip  = 1'b0;
    cpop     = 1'b0;
    cpush    = 1'b0;
    rd_mem   = 1'b0;
    wr_mem   = 1'b0;
    if (insn.lit.flag)
    begin
      alu_sel  = alu_lit;
      push     = 1'b1;
      load_stk = 1'b1;
    end
    else
    begin
      casez (insn.op.major)
        4'b0000:
        begin
          src_a   = src_ip;
          alu_sel = alu_addr;
          load_ip = 1'b1;
          cpush   = insn.op.low[0];  // call
        end
        4'b0001:
        begin
          src_a   = src_ip;
          alu_sel = insn.op.low[0] ? alu_bnz : alu_bz;
          load_ip = 1'b1;
          pop     = 1'b1;
        end
        4'b0010:
        begin
          src_a    = insn.op.src;
          alu_sel  = alu_addr;
          rd_mem   = 1'b1;
          push     = 1'b1;
          load_stk = 1'b1;
        end
        4'b0011:
        begin
          src_a   = insn.op.src;
          alu_sel = alu_addr;
          wr_mem  = 1'b1;
          pop     = 1'b1;
        end
        4'b0100:
        begin
          src_a    = insn.op.src;
          alu_sel  = alu_addr;
          push     = 1'b1;
          load_stk = 1'b1;
        end
        4'b0101:
        begin
          src_a   = src_fp;
          alu_sel = alu_addr;
          load_fp = 1'b1;
        end
        4'b0111:
        begin
          if (!insn.op.src[1])
          begin
            alu_sel  = insn.op.low[5:0];
            pop      = insn.op.low[6];
            push     = insn.op.low[7];
            wr_stk1  = insn.op.low[3];
            load_stk = 1'b1;
          end
          else
          begin
            casez (insn.op.low[3:0])
              4'b0000:
              begin
                src_a   = src_cstk;  // return
                load_ip = 1'b1;
                cpop    = 1'b1;
              end
              4'b0010:
              begin
                src_a   = src_cstk;
                load_fp = 1'b1;
                cpop    = 1'b1;
              end
              4'b0011:
              begin
                src_a = src_fp;
                cpush = 1'b1;
              end
              4'b10??:
              begin
                rd_mem   = 1'b1;
                load_stk = 1'b1;
              end
              4'b11??:
              begin
                wr_mem   = 1'b1;
                pop      = 1'b1;
                load_stk = ~insn.op.low[1];  // 110x keeps the address
              end
              default: ;
            endcase
          end
        end
        default: ;  // 0110 reserved
      endcase
    end
  end

endmodule

//--- hw/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

  typedef enum logic [2:0] {
    idle,
    fetch,
    fetch_rel,   // fetch done, waiting for ack low
    exec,
    mem,
    mem_rel,
    fault
  } ctrl_state_t;

  // ********************
  // bus timing
  localparam int bus_timeout = 32;  // cycles without an ack edge
  localparam int timer_w     = $clog2(bus_timeout + 1);

endpackage

//--- hw/cpu_isa_pkg.sv
package cpu_isa_pkg;

  localparam int word_w = 16;

  // one instruction word, read as a literal or as an operation
  typedef union packed {
    struct packed {
      logic        flag;   // set for a literal
      logic [14:0] value;
    } lit;
    struct packed {
      logic [3:0] major;
      logic [1:0] src;     // bit 11 also splits reg and misc ops
      logic [9:0] low;     // offset, subcode, flags
    } op;
  } insn_t;

  localparam logic [3:0] op_reg = 4'h7;

  // ********************
  // operand sources
  localparam logic [1:0] src_stk0 = 2'h0;
  localparam logic [1:0] src_fp   = 2'h1;
  localparam logic [1:0] src_ip   = 2'h2;
  localparam logic [1:0] src_cstk = 2'h3;

  // ********************
  // alu selects
  localparam logic [5:0] alu_add  = 6'h01;
  localparam logic [5:0] alu_sub  = 6'h02;
  localparam logic [5:0] alu_and  = 6'h03;
  localparam logic [5:0] alu_or   = 6'h04;
  localparam logic [5:0] alu_xor  = 6'h05;
  localparam logic [5:0] alu_shl  = 6'h06;
  localparam logic [5:0] alu_shr  = 6'h07;
  localparam logic [5:0] alu_swap = 6'h08;  // bit 3 set, so stk1 gets the old top
  localparam logic [5:0] alu_lit  = 6'h0f;
  localparam logic [5:0] alu_addr = 6'h20;
  localparam logic [5:0] alu_bz   = 6'h30;
  localparam logic [5:0] alu_bnz  = 6'h31;

endpackage
